//--- design/cmd_fifo.sv
// Command word FIFO
// Circular buffer with host clear-to-send

module cmd_fifo
    import spi_display_pkg::*;
#(
    parameter int FIFO_DEPTH = 8
)
(
    input  logic      clk,
    input  logic      resetn_in,

    // Push side from the receiver without back-pressure
    input  logic      word_valid,
    input  cmd_word_t word_data,

    // Pop side to the renderer
    output logic      cmd_valid,
    input  logic      cmd_ready,
    output cmd_word_t cmd_data,

    // High while at least two entries are free
    output logic      serial_cts
);

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);
    localparam logic [PTR_W-1:0] LAST_PTR   = PTR_W'(FIFO_DEPTH - 1);
    localparam logic [CNT_W-1:0] FULL_LEVEL = CNT_W'(FIFO_DEPTH);
    localparam logic [CNT_W-1:0] CTS_LEVEL  = CNT_W'(FIFO_DEPTH - 2);

    cmd_word_t        mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             push;
    logic             pop;

    // Full FIFO drops the word and the assertion below flags it
    assign push      = word_valid && (count != FULL_LEVEL);
    assign pop       = cmd_valid && cmd_ready;
    assign cmd_valid = (count != '0);
    assign cmd_data  = mem[rd_ptr];

    always_ff @(posedge clk)
    begin
        if (push)
        begin
            mem[wr_ptr] <= word_data;
        end
    end

    ////////////////////
    // Pointers and level
    ////////////////////
    always_ff @(posedge clk)
    begin
        if (resetn_in)
        begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            serial_cts <= 1'b1;
        end
        else
        begin
            if (push)
            begin
                wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
            end
            if (pop)
            begin
                rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // One cycle behind the level so one spare entry is kept
            serial_cts <= (count <= CTS_LEVEL);
        end
    end

    // Host must honour serial_cts
    assert property (@(posedge clk) disable iff (resetn_in)
        word_valid |-> (count != FULL_LEVEL));

    // Empty level must match caught-up pointers
    assert property (@(posedge clk) disable iff (resetn_in)
        (count == '0) |-> (rd_ptr == wr_ptr));

endmodule

//--- design/display_link.sv
// Panel SPI link
// Pixel serializer and host bypass

module display_link
    import spi_display_pkg::*;
#(
    parameter int CLOCK_DIV = 1
)
(
    input  logic   clk,
    input  logic   resetn_in,

    // Pixel stream from the renderer
    input  logic   pix_valid,
    output logic   pix_ready,
    input  pixel_t pix_data,
    input  logic   pix_last,

    // Host bypass inputs
    input  logic   serial_tft_mux,
    input  logic   serial_mosi,
    input  logic   serial_sck,
    input  logic   tft_cs,
    input  logic   tft_dc,

    // Panel pins
    output logic   display_mosi,
    output logic   display_sck,
    output logic   display_cs,
    output logic   display_dc,
    output logic   display_reset
);

    localparam int DIV_W = (CLOCK_DIV > 0) ? $clog2(CLOCK_DIV + 1) : 1;
    localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(CLOCK_DIV);

    link_state_t      state;
    logic             mux_reg;
    logic             reset_reg;
    logic [DIV_W-1:0] div_cnt;
    logic             half_tick;
    logic             sck_reg;
    pixel_t           shift_reg;
    logic [3:0]       bit_cnt;
    logic             last_reg;
    logic             shift_edge;
    logic             pix_take;
    logic             bypass;

    // Half sck period elapsed
    assign half_tick  = (div_cnt == DIV_LAST);
    // Falling sck edge, next bit goes out
    assign shift_edge = (state == L_SHIFT) && half_tick && sck_reg;
    assign pix_ready  = (state == L_IDLE) && !mux_reg;
    assign pix_take   = pix_valid && pix_ready;
    assign bypass     = (state == L_BYPASS);

    ////////////////////
    // Link FSM
    ////////////////////
    always_ff @(posedge clk)
    begin
        if (resetn_in)
        begin
            state    <= L_IDLE;
            mux_reg  <= 1'b0;
            div_cnt  <= '0;
            sck_reg  <= 1'b0;
            bit_cnt  <= 4'd0;
            last_reg <= 1'b0;
        end
        else
        begin
            mux_reg <= serial_tft_mux;
            case (state)
                L_IDLE:
                begin
                    div_cnt <= '0;
                    sck_reg <= 1'b0;
                    bit_cnt <= 4'd0;
                    if (mux_reg)
                    begin
                        state <= L_BYPASS;
                    end
                    else if (pix_take)
                    begin
                        last_reg <= pix_last;
                        state    <= L_SHIFT;
                    end
                end
                L_SHIFT:
                begin
                    div_cnt <= half_tick ? '0 : div_cnt + 1'b1;
                    if (half_tick)
                    begin
                        sck_reg <= !sck_reg;
                        if (sck_reg)
                        begin
                            // Wraps to zero after bit 15, ready for the gap phase
                            bit_cnt <= bit_cnt + 4'd1;
                            if (bit_cnt == 4'd15)
                            begin
                                state <= last_reg ? L_GAP : L_IDLE;
                            end
                        end
                    end
                end
                L_GAP:
                begin
                    // bit_cnt[0] marks the second half of the gap period
                    div_cnt <= half_tick ? '0 : div_cnt + 1'b1;
                    if (half_tick)
                    begin
                        bit_cnt <= bit_cnt + 4'd1;
                        if (bit_cnt[0])
                        begin
                            state <= L_IDLE;
                        end
                    end
                end
                L_BYPASS:
                begin
                    if (!mux_reg)
                    begin
                        state <= L_IDLE;
                    end
                end
                default: state <= L_IDLE;
            endcase
        end
    end

    // Pixel shift register, MSB first
    always_ff @(posedge clk)
    begin
        if (pix_take)
        begin
            shift_reg <= pix_data;
        end
        else if (shift_edge)
        begin
            shift_reg <= {shift_reg[14:0], 1'b0};
        end
    end

    // Panel reset copy
    always_ff @(posedge clk)
    begin
        reset_reg <= resetn_in;
    end

    ////////////////////
    // Pin mux
    ////////////////////
    assign display_mosi  = bypass ? serial_mosi : shift_reg[15];
    assign display_sck   = bypass ? serial_sck : sck_reg;
    // CS pulses high only in the frame gap
    assign display_cs    = bypass ? tft_cs : (state == L_GAP);
    assign display_dc    = bypass ? tft_dc : 1'b1;
    assign display_reset = reset_reg;

endmodule

//--- design/serial_cmd_receiver.sv
// Host SPI slave
// Mode 0 command word receiver

module serial_cmd_receiver
    import spi_display_pkg::*;
(
    input  logic      clk,
    input  logic      resetn_in,

    // Host serial pins, asynchronous to clk
    input  logic      serial_mosi,
    input  logic      serial_sck,
    input  logic      serial_cs,

    // Assembled command words
    output logic      word_valid,
    output cmd_word_t word_data
);

    ////////////////////
    // Pin synchronizers
    ////////////////////
    // Two flops per pin, third sck stage only for edge detect
    logic [2:0] sck_sync;
    logic [1:0] mosi_sync;
    logic [1:0] cs_sync;
    logic       sck_rise;

    always_ff @(posedge clk)
    begin
        if (resetn_in)
        begin
            sck_sync  <= 3'b000;
            mosi_sync <= 2'b00;
            // Chip select idles high
            cs_sync   <= 2'b11;
        end
        else
        begin
            sck_sync  <= {sck_sync[1:0], serial_sck};
            mosi_sync <= {mosi_sync[0], serial_mosi};
            cs_sync   <= {cs_sync[0], serial_cs};
        end
    end

    // Rising sck edge seen at the second stage
    assign sck_rise = sck_sync[1] && !sck_sync[2];

    ////////////////////
    // Word assembly
    ////////////////////
    logic [4:0] bit_cnt;

    always_ff @(posedge clk)
    begin
        if (resetn_in)
        begin
            bit_cnt    <= 5'd0;
            word_valid <= 1'b0;
        end
        else
        begin
            // One cycle pulse by default
            word_valid <= 1'b0;
            if (cs_sync[1])
            begin
                // Deselected, drop any partial word
                bit_cnt <= 5'd0;
            end
            else if (sck_rise)
            begin
                bit_cnt <= bit_cnt + 5'd1;
                // 32nd bit, counter wraps to zero
                if (bit_cnt == 5'd31)
                begin
                    word_valid <= 1'b1;
                end
            end
        end
    end

    // MSB first, shifts in from the bottom
    always_ff @(posedge clk)
    begin
        if (!cs_sync[1] && sck_rise)
        begin
            word_data <= {word_data[30:0], mosi_sync[1]};
        end
    end

endmodule

//--- design/span_renderer.sv
// Span renderer
// FILL and RESTART command decoder

module span_renderer
    import spi_display_pkg::*;
#(
    parameter int FRAME_PIXELS = 64
)
(
    input  logic      clk,
    input  logic      resetn_in,

    // Commands from the FIFO
    input  logic      cmd_valid,
    output logic      cmd_ready,
    input  cmd_word_t cmd_data,

    // Pixel stream to the panel link
    output logic      pix_valid,
    input  logic      pix_ready,
    output pixel_t    pix_data,
    output logic      pix_last
);

    localparam int POS_W = (FRAME_PIXELS > 1) ? $clog2(FRAME_PIXELS) : 1;
    localparam logic [POS_W-1:0] LAST_POS = POS_W'(FRAME_PIXELS - 1);

    render_state_t    state;
    span_len_t        remaining;
    pixel_t           colour;
    logic [POS_W-1:0] frame_pos;
    opcode_t          cmd_op;
    span_len_t        cmd_len;
    logic             cmd_take;
    logic             pix_take;

    // Command fields
    assign cmd_op  = cmd_data[31:30];
    assign cmd_len = cmd_data[29:16];

    // Only takes a command between spans
    assign cmd_ready = (state == R_IDLE);
    assign cmd_take  = cmd_valid && cmd_ready;
    assign pix_valid = (state == R_FILL);
    assign pix_take  = pix_valid && pix_ready;
    assign pix_data  = colour;
    assign pix_last  = (frame_pos == LAST_POS);

    ////////////////////
    // Decoder FSM
    ////////////////////
    always_ff @(posedge clk)
    begin
        if (resetn_in)
        begin
            state     <= R_IDLE;
            remaining <= '0;
            frame_pos <= '0;
        end
        else
        begin
            case (state)
                R_IDLE:
                begin
                    if (cmd_take)
                    begin
                        case (cmd_op)
                            OP_FILL:
                            begin
                                // Zero length span is dropped
                                if (cmd_len != '0)
                                begin
                                    remaining <= cmd_len;
                                    state     <= R_FILL;
                                end
                            end
                            OP_RESTART: frame_pos <= '0;
                            // NOP and reserved code
                            default: ;
                        endcase
                    end
                end
                R_FILL:
                begin
                    if (pix_take)
                    begin
                        // Frame position wraps every FRAME_PIXELS
                        frame_pos <= (frame_pos == LAST_POS) ? '0 : frame_pos + 1'b1;
                        remaining <= remaining - 1'b1;
                        if (remaining == span_len_t'(1))
                        begin
                            state <= R_IDLE;
                        end
                    end
                end
                default: state <= R_IDLE;
            endcase
        end
    end

    // Span colour
    always_ff @(posedge clk)
    begin
        if (cmd_take && (cmd_op == OP_FILL))
        begin
            colour <= cmd_data[15:0];
        end
    end

    // Stalled pixel must hold until the link takes it
    assert property (@(posedge clk) disable iff (resetn_in)
        pix_valid && !pix_ready |=> pix_valid && $stable(pix_data) && $stable(pix_last));

endmodule

//--- design/spi_display_bridge.sv
// SPI display bridge top level

module spi_display_bridge
    import spi_display_pkg::*;
#(
    parameter int FIFO_DEPTH   = 8,
    parameter int FRAME_PIXELS = 64,
    parameter int CLOCK_DIV    = 1
)
(
    input  logic clk,
    input  logic resetn_in,

    // Host serial link
    input  logic serial_mosi,
    input  logic serial_sck,
    input  logic serial_cs,
    output logic serial_cts,
    input  logic serial_tft_mux,
    input  logic tft_cs,
    input  logic tft_dc,

    // Panel pins
    output logic display_mosi,
    output logic display_sck,
    output logic display_cs,
    output logic display_dc,
    output logic display_reset
);

    ////////////////////
    // Internal streams
    ////////////////////
    logic      word_valid;
    cmd_word_t word_data;
    logic      cmd_valid;
    logic      cmd_ready;
    cmd_word_t cmd_data;
    logic      pix_valid;
    logic      pix_ready;
    pixel_t    pix_data;
    logic      pix_last;

    serial_cmd_receiver receiver (
        .clk         (clk),
        .resetn_in   (resetn_in),
        .serial_mosi (serial_mosi),
        .serial_sck  (serial_sck),
        .serial_cs   (serial_cs),
        .word_valid  (word_valid),
        .word_data   (word_data)
    );

    cmd_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) fifo (
        .clk        (clk),
        .resetn_in  (resetn_in),
        .word_valid (word_valid),
        .word_data  (word_data),
        .cmd_valid  (cmd_valid),
        .cmd_ready  (cmd_ready),
        .cmd_data   (cmd_data),
        .serial_cts (serial_cts)
    );

    span_renderer #(
        .FRAME_PIXELS (FRAME_PIXELS)
    ) renderer (
        .clk       (clk),
        .resetn_in (resetn_in),
        .cmd_valid (cmd_valid),
        .cmd_ready (cmd_ready),
        .cmd_data  (cmd_data),
        .pix_valid (pix_valid),
        .pix_ready (pix_ready),
        .pix_data  (pix_data),
        .pix_last  (pix_last)
    );

    // Panel side with host bypass
    display_link #(
        .CLOCK_DIV (CLOCK_DIV)
    ) link (
        .clk            (clk),
        .resetn_in      (resetn_in),
        .pix_valid      (pix_valid),
        .pix_ready      (pix_ready),
        .pix_data       (pix_data),
        .pix_last       (pix_last),
        .serial_tft_mux (serial_tft_mux),
        .serial_mosi    (serial_mosi),
        .serial_sck     (serial_sck),
        .tft_cs         (tft_cs),
        .tft_dc         (tft_dc),
        .display_mosi   (display_mosi),
        .display_sck    (display_sck),
        .display_cs     (display_cs),
        .display_dc     (display_dc),
        .display_reset  (display_reset)
    );

endmodule

//--- design/spi_display_pkg.sv
// Display bridge shared types
// Command words, pixels and FSM states

package spi_display_pkg;

    ////////////////////
    // Word types
    ////////////////////
    // Command word: [31:30] opcode, [29:16] span length, [15:0] colour
    typedef logic [31:0] cmd_word_t;
    // RGB565 pixel
    typedef logic [15:0] pixel_t;
    // Pixel count of one span
    typedef logic [13:0] span_len_t;

    ////////////////////
    // Command opcodes
    ////////////////////
    typedef logic [1:0] opcode_t;
    localparam opcode_t OP_NOP     = 2'd0;
    localparam opcode_t OP_FILL    = 2'd1;
    localparam opcode_t OP_RESTART = 2'd2;
    // Code 3 is reserved and dropped by the renderer

    // Renderer and panel link state machines
    typedef enum logic {R_IDLE, R_FILL} render_state_t;
    typedef enum logic [1:0] {L_IDLE, L_SHIFT, L_GAP, L_BYPASS} link_state_t;

endpackage

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the display bridge testbench with Verilator

set -u
cd "$(dirname "$0")"

BUILD_DIR=obj_dir
SIM_BIN=spi_display_sim
LOG_FILE=sim.log

verilator --binary --timing --assert \
    -f spi_display_bridge.f \
    --top-module spi_display_tb \
    -Mdir "$BUILD_DIR" -o "$SIM_BIN"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"
if [ $sim_status -ne 0 ]; then
    echo "Simulator exited with status $sim_status"
fi

if grep -q "^Simulation finished: PASS$" "$LOG_FILE"; then
    exit 0
fi
exit 1

//--- spi_display_bridge.f
design/spi_display_pkg.sv
design/serial_cmd_receiver.sv
design/cmd_fifo.sv
design/span_renderer.sv
design/display_link.sv
design/spi_display_bridge.sv
tb/spi_display_tb.sv

//--- tb/spi_display_golden.txt
# C <command word hex> | P <pixel hex> <repeat count decimal> | F frame boundary
# Command lines first, then the expected panel stream in order
C 400AF800
C 40001234
C 00005555
C 401407E0
C 4028001F
C 80000000
C 400CFFFF
C 400C8410
C 400CA5A5
C 400C5A5A
C 400C0F0F
C 4008F0F0
C 40061111
C C0037777
C 40362222
P F800 10
P 07E0 20
P 001F 34
F
P 001F 6
P FFFF 12
P 8410 12
P A5A5 12
P 5A5A 12
P 0F0F 12
P F0F0 4
F
P F0F0 4
P 1111 6
P 2222 54
F

//--- tb/spi_display_tb.sv
// Display bridge testbench
// SPI host model and panel monitor

module spi_display_tb
    import spi_display_pkg::*;
();

    localparam int     FIFO_DEPTH   = 8;
    localparam int     FRAME_PIXELS = 64;
    localparam int     CLOCK_DIV    = 1;
    localparam int     MAX_CMDS     = 64;
    localparam int     MAX_EXP      = 1024;
    // clk cycles per host sck half period
    localparam int     HOST_HALF    = 2;
    // Host sck period in time units
    localparam longint SCK_PERIOD   = 160;

    logic clk;
    logic resetn_in;
    logic serial_mosi;
    logic serial_sck;
    logic serial_cs;
    logic serial_tft_mux;
    logic tft_cs;
    logic tft_dc;
    logic serial_cts;
    logic display_mosi;
    logic display_sck;
    logic display_cs;
    logic display_dc;
    logic display_reset;

    // Golden data
    cmd_word_t cmd_list [MAX_CMDS];
    logic      exp_frame [MAX_EXP];
    pixel_t    exp_word [MAX_EXP];
    int        n_cmds;
    int        n_exp;
    int        n_pixels;
    int        exp_idx;

    // Monitor and run state
    logic        monitor_on;
    logic        loaded;
    logic        cts_went_low;
    pixel_t      mon_word;
    int          mon_bits;
    logic [31:0] lfsr_state;
    longint      watchdog_limit;

    spi_display_bridge #(
        .FIFO_DEPTH   (FIFO_DEPTH),
        .FRAME_PIXELS (FRAME_PIXELS),
        .CLOCK_DIV    (CLOCK_DIV)
    ) uut (
        .clk            (clk),
        .resetn_in      (resetn_in),
        .serial_mosi    (serial_mosi),
        .serial_sck     (serial_sck),
        .serial_cs      (serial_cs),
        .serial_cts     (serial_cts),
        .serial_tft_mux (serial_tft_mux),
        .tft_cs         (tft_cs),
        .tft_dc         (tft_dc),
        .display_mosi   (display_mosi),
        .display_sck    (display_sck),
        .display_cs     (display_cs),
        .display_dc     (display_dc),
        .display_reset  (display_reset)
    );

    always #20 clk = ~clk;

    ////////////////////
    // Helpers
    ////////////////////
    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic expect_pin(input string name, input logic expected, input logic actual);
        assert (actual === expected)
        else abort_run($sformatf("ERROR: %s expected %h got %h", name, expected, actual));
    endtask

    // Galois LFSR with taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        lfsr_step = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic draw_bit(output logic b);
        b = lfsr_state[0];
        lfsr_state = lfsr_step(lfsr_state);
    endtask

    // Reads command words and expands P repeat counts
    task automatic load_golden();
        int             fd;
        int             code;
        int             rep;
        logic [7:0]     tag;
        logic [31:0]    val;
        logic [1023:0]  skip_line;
        fd = $fopen("tb/spi_display_golden.txt", "r");
        if (fd == 0)
        begin
            abort_run("could not open the golden data file");
        end
        n_cmds   = 0;
        n_exp    = 0;
        n_pixels = 0;
        code = $fscanf(fd, " %c", tag);
        while (code == 1)
        begin
            case (tag)
                "#": code = $fgets(skip_line, fd);
                "C":
                begin
                    code = $fscanf(fd, "%h", val);
                    cmd_list[n_cmds] = val;
                    n_cmds = n_cmds + 1;
                end
                "P":
                begin
                    code = $fscanf(fd, "%h %d", val, rep);
                    for (int r = 0; r < rep; r++)
                    begin
                        exp_frame[n_exp] = 1'b0;
                        exp_word[n_exp]  = val[15:0];
                        n_exp = n_exp + 1;
                    end
                    n_pixels = n_pixels + rep;
                end
                "F":
                begin
                    exp_frame[n_exp] = 1'b1;
                    exp_word[n_exp]  = '0;
                    n_exp = n_exp + 1;
                end
                default: abort_run("unknown line tag in the golden data file");
            endcase
            code = $fscanf(fd, " %c", tag);
        end
        $fclose(fd);
    endtask

    ////////////////////
    // SPI host model
    ////////////////////
    // Sends one mode 0 word MSB first from a falling clk edge
    task automatic send_word(input cmd_word_t w);
        // Start only with room in the FIFO
        while (!serial_cts)
        begin
            @(negedge clk);
        end
        serial_cs = 1'b0;
        repeat (HOST_HALF) @(negedge clk);
        for (int i = 31; i >= 0; i--)
        begin
            serial_mosi = w[i];
            repeat (HOST_HALF) @(negedge clk);
            serial_sck = 1'b1;
            repeat (HOST_HALF) @(negedge clk);
            serial_sck = 1'b0;
        end
        repeat (HOST_HALF) @(negedge clk);
        serial_cs = 1'b1;
        // Lets serial_cts catch up with the push
        repeat (2 * HOST_HALF) @(negedge clk);
    endtask

    ////////////////////
    // Bypass check
    ////////////////////
    task automatic run_bypass_check();
        logic b_mosi;
        logic b_sck;
        logic b_cs;
        logic b_dc;
        serial_mosi    = 1'b0;
        serial_sck     = 1'b0;
        tft_cs         = 1'b0;
        tft_dc         = 1'b0;
        serial_tft_mux = 1'b1;
        // dc low means the link has left its pixel and entered bypass
        while (display_dc !== 1'b0)
        begin
            @(negedge clk);
        end
        assert (mon_bits == 0)
        else abort_run("bypass took over the panel in the middle of a pixel");
        monitor_on = 1'b0;
        repeat (2) @(negedge clk);
        for (int n = 0; n < 24; n++)
        begin
            draw_bit(b_mosi);
            draw_bit(b_sck);
            draw_bit(b_cs);
            draw_bit(b_dc);
            serial_mosi = b_mosi;
            serial_sck  = b_sck;
            tft_cs      = b_cs;
            tft_dc      = b_dc;
            @(negedge clk);
            expect_pin("display_mosi", b_mosi, display_mosi);
            expect_pin("display_sck", b_sck, display_sck);
            expect_pin("display_cs", b_cs, display_cs);
            expect_pin("display_dc", b_dc, display_dc);
        end
        // Quiet pins before handing the panel back
        serial_mosi = 1'b0;
        serial_sck  = 1'b0;
        tft_cs      = 1'b0;
        tft_dc      = 1'b0;
        @(negedge clk);
        serial_tft_mux = 1'b0;
        while (display_dc !== 1'b1)
        begin
            @(negedge clk);
        end
        monitor_on = 1'b1;
        tft_cs     = 1'b1;
        tft_dc     = 1'b1;
    endtask

    ////////////////////
    // Panel monitor
    ////////////////////
    always @(posedge display_sck)
    begin
        if (monitor_on && !resetn_in && !display_cs)
        begin
            mon_word = {mon_word[14:0], display_mosi};
            mon_bits = mon_bits + 1;
            if (mon_bits == 16)
            begin
                assert (exp_idx < n_exp)
                else abort_run("panel received more pixels than the golden data holds");
                assert (!exp_frame[exp_idx])
                else abort_run($sformatf("pixel came where frame boundary %0d was due", exp_idx));
                assert (mon_word === exp_word[exp_idx])
                else abort_run($sformatf("ERROR: display_mosi expected %h got %h",
                                         exp_word[exp_idx], mon_word));
                exp_idx  = exp_idx + 1;
                mon_bits = 0;
            end
        end
    end

    // Chip select high marks a frame gap
    always @(posedge display_cs)
    begin
        if (monitor_on && !resetn_in)
        begin
            assert (mon_bits == 0)
            else abort_run("display_cs rose in the middle of a pixel");
            assert ((exp_idx < n_exp) && exp_frame[exp_idx])
            else abort_run($sformatf("display_cs rose at golden entry %0d, not a frame end",
                                     exp_idx));
            exp_idx = exp_idx + 1;
        end
    end

    always @(posedge clk)
    begin
        if (!resetn_in && (serial_cts === 1'b0))
        begin
            cts_went_low <= 1'b1;
        end
    end

    // Watchdog
    initial
    begin
        wait (loaded);
        #(watchdog_limit);
        abort_run($sformatf("timeout, the run did not finish within %0d time units",
                            watchdog_limit));
    end

    ////////////////////
    // Main sequence
    ////////////////////
    initial
    begin
        clk            = 1'b0;
        resetn_in      = 1'b1;
        serial_mosi    = 1'b0;
        serial_sck     = 1'b0;
        serial_cs      = 1'b1;
        serial_tft_mux = 1'b0;
        tft_cs         = 1'b1;
        tft_dc         = 1'b1;
        monitor_on     = 1'b0;
        loaded         = 1'b0;
        cts_went_low   = 1'b0;
        exp_idx        = 0;
        mon_bits       = 0;
        mon_word       = '0;
        lfsr_state     = 32'h60a5_9f1d;
        load_golden();
        // Four host word times per golden word plus margin
        watchdog_limit = longint'(n_cmds + n_pixels) * 32 * SCK_PERIOD * 4 + 400000;
        loaded = 1'b1;

        // Reset for 16 cycles
        repeat (16) @(negedge clk);
        expect_pin("display_reset", 1'b1, display_reset);
        resetn_in = 1'b0;
        repeat (2) @(negedge clk);
        expect_pin("display_reset", 1'b0, display_reset);
        expect_pin("display_cs", 1'b0, display_cs);
        expect_pin("display_sck", 1'b0, display_sck);
        expect_pin("serial_cts", 1'b1, serial_cts);
        monitor_on = 1'b1;

        // Bypass lands halfway through the commands
        for (int i = 0; i < n_cmds; i++)
        begin
            if (i == n_cmds / 2)
            begin
                run_bypass_check();
            end
            send_word(cmd_list[i]);
        end

        while (exp_idx < n_exp)
        begin
            @(negedge clk);
        end
        // Quiet window of one pixel time for stray panel bits
        repeat (32 * (CLOCK_DIV + 1)) @(negedge clk);
        assert (cts_went_low)
        else abort_run("serial_cts never dropped during the command burst");
        assert (mon_bits == 0)
        else abort_run("a partial pixel was left on the panel pins");
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule
